/* source/mmu_pkg.sv */
package mmu_pkg;

    localparam int PAGE_OFFSET_BITS = 12;  // 4 KiB pages
    localparam int ASID_LENGTH      = 9;

    typedef logic [31:0]                          vaddr_t;
    typedef logic [33:0]                          paddr_t;  // Sv32 physical space
    typedef logic [21:0]                          ppn_t;
    typedef logic [31-PAGE_OFFSET_BITS:0]         vpn_t;
    typedef logic [ASID_LENGTH-1:0]               asid_t;

    // low ten bits of a PTE, msb first
    typedef struct packed {
        logic [1:0] rsw;
        logic       dirty;
        logic       accessed;
        logic       global;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        ppn_t       ppn;
        pte_perms_t perms;
    } pte_sv32_t;

    typedef enum logic [1:0] {
        ACCESS_NONE,
        ACCESS_LOAD,
        ACCESS_STORE,
        ACCESS_INSN
    } access_t;

    // TLB stage
    typedef enum logic [2:0] {
        CLEAR,
        LOOKUP,
        RESPOND,
        FETCH,
        FENCE
    } tlb_state_t;

    // page walker
    typedef enum logic [1:0] {
        IDLE,
        LEVEL1,
        LEVEL0,
        DONE
    } walk_state_t;

endpackage

/* source/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top #(
    parameter int TLB_SIZE  = 16,
    parameter int TLB_ASSOC = 2,
    parameter bit IS_ITLB   = 0
) (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            ren,
    input  logic            wen,
    input  mmu_pkg::vaddr_t vaddr,
    input  logic            trans_on,
    input  logic            priv_user,
    input  logic            sum,
    input  mmu_pkg::asid_t  satp_asid,
    input  mmu_pkg::ppn_t   satp_ppn,
    input  logic            fence,
    input  mmu_pkg::vaddr_t fence_va,
    input  mmu_pkg::asid_t  fence_asid,
    input  logic [31:0]     mem_rdata,
    input  logic            mem_busy,
    input  logic            mem_error,
    output logic            busy,
    output mmu_pkg::paddr_t paddr,
    output logic            fault_load_page,
    output logic            fault_store_page,
    output logic            fault_insn_page,
    output logic            tlb_miss,
    output logic            fence_done,
    output logic            mem_ren,
    output mmu_pkg::paddr_t mem_addr
);
    import mmu_pkg::*;

    logic      hit;
    pte_sv32_t hit_pte;
    access_t   access;
    logic      walk_fault;

    walk_bus_if walk_bus ();

    tlb #(
        .TLB_SIZE  (TLB_SIZE),
        .TLB_ASSOC (TLB_ASSOC),
        .IS_ITLB   (IS_ITLB)
    ) tlb0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .ren        (ren),
        .wen        (wen),
        .vaddr      (vaddr),
        .trans_on   (trans_on),
        .satp_asid  (satp_asid),
        .fence      (fence),
        .fence_va   (fence_va),
        .fence_asid (fence_asid),
        .tlb_miss   (tlb_miss),
        .fence_done (fence_done),
        .hit        (hit),
        .hit_pte    (hit_pte),
        .access     (access),
        .walk_fault (walk_fault),
        .walk       (walk_bus.tlb)
    );

    page_walker walker0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .satp_ppn  (satp_ppn),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy),
        .mem_error (mem_error),
        .mem_ren   (mem_ren),
        .mem_addr  (mem_addr),
        .walk      (walk_bus.walker)
    );

    page_perm_check perm0 (
        .CLK              (CLK),
        .nRST             (nRST),
        .hit              (hit),
        .walk_fault       (walk_fault),
        .pte              (hit_pte),
        .access           (access),
        .vaddr            (vaddr),
        .trans_on         (trans_on),
        .priv_user        (priv_user),
        .sum              (sum),
        .busy             (busy),
        .paddr            (paddr),
        .fault_load_page  (fault_load_page),
        .fault_store_page (fault_store_page),
        .fault_insn_page  (fault_insn_page)
    );

endmodule

/* source/page_perm_check.sv */
`timescale 1ns/1ps

module page_perm_check (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               hit,
    input  logic               walk_fault,
    input  mmu_pkg::pte_sv32_t pte,
    input  mmu_pkg::access_t   access,
    input  mmu_pkg::vaddr_t    vaddr,
    input  logic               trans_on,
    input  logic               priv_user,
    input  logic               sum,
    output logic               busy,
    output mmu_pkg::paddr_t    paddr,
    output logic               fault_load_page,
    output logic               fault_store_page,
    output logic               fault_insn_page
);
    import mmu_pkg::*;

    logic       respond;
    logic       resp_q;
    logic       fault;
    logic       is_load;
    logic       is_store;
    logic       is_insn;
    pte_perms_t perms;
    paddr_t     next_paddr;

    assign respond  = hit || walk_fault;
    assign perms    = pte.perms;
    assign is_load  = (access == ACCESS_LOAD);
    assign is_store = (access == ACCESS_STORE);
    assign is_insn  = (access == ACCESS_INSN);

    always_comb begin
        fault = trans_on && (walk_fault
              || !perms.accessed                           // no hardware A/D update
              || (is_store && !perms.dirty)
              || (is_load && !perms.readable)
              || (is_store && !perms.writable)
              || (is_insn && !perms.executable)
              || (priv_user && !perms.user)
              || (!priv_user && perms.user && (is_insn || !sum)));
        if (!trans_on) begin
            next_paddr = paddr_t'(vaddr);  // bare mode
        end else if (fault) begin
            next_paddr = '0;
        end else begin
            next_paddr = {pte.ppn, vaddr[PAGE_OFFSET_BITS-1:0]};
        end
    end

    assign busy = !resp_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_q           <= 1'b0;
            fault_load_page  <= 1'b0;
            fault_store_page <= 1'b0;
            fault_insn_page  <= 1'b0;
        end else begin
            resp_q           <= respond;
            fault_load_page  <= respond && fault && is_load;
            fault_store_page <= respond && fault && is_store;
            fault_insn_page  <= respond && fault && is_insn;
        end
    end

    always_ff @(posedge CLK) begin
        if (respond) begin
            paddr <= next_paddr;
        end
    end

endmodule

/* source/page_walker.sv */
`timescale 1ns/1ps

module page_walker (
    input  logic            CLK,
    input  logic            nRST,
    input  mmu_pkg::ppn_t   satp_ppn,
    input  logic [31:0]     mem_rdata,
    input  logic            mem_busy,
    input  logic            mem_error,
    output logic            mem_ren,
    output mmu_pkg::paddr_t mem_addr,
    walk_bus_if.walker      walk
);
    import mmu_pkg::*;

    walk_state_t state;
    walk_state_t next_state;
    pte_sv32_t   pte_q;  // level-1 pointer, then the leaf
    logic        err_q;

    pte_sv32_t rd_pte;
    logic      rd_bad;
    logic      rd_leaf;
    logic      rd_done;

    assign rd_pte  = pte_sv32_t'(mem_rdata);
    assign rd_bad  = mem_error || !rd_pte.perms.valid ||
                     (rd_pte.perms.writable && !rd_pte.perms.readable);
    assign rd_leaf = rd_pte.perms.readable || rd_pte.perms.executable;
    assign rd_done = mem_ren && !mem_busy;

    assign mem_ren  = (state == LEVEL1) || (state == LEVEL0);
    assign mem_addr = (state == LEVEL1) ? {satp_ppn, walk.vpn[19:10], 2'b00}
                    : {pte_q.ppn, walk.vpn[9:0], 2'b00};

    assign walk.done  = (state == DONE);
    assign walk.pte   = pte_q;
    assign walk.error = err_q;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (walk.req) begin
                    next_state = LEVEL1;
                end
            end
            LEVEL1: begin
                if (!mem_busy) begin
                    next_state = (rd_bad || rd_leaf) ? DONE : LEVEL0;  // no megapages
                end
            end
            LEVEL0: begin
                if (!mem_busy) begin
                    next_state = DONE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            state <= next_state;
            if (rd_done) begin
                // leaf at level 1 or pointer at level 0 both fault
                err_q <= rd_bad || ((state == LEVEL1) ? rd_leaf : !rd_leaf);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rd_done) begin
            pte_q <= rd_pte;
        end
    end

endmodule

/* source/tlb.sv */
`timescale 1ns/1ps

module tlb #(
    parameter int TLB_SIZE  = 16,
    parameter int TLB_ASSOC = 2,  // TLB_SIZE / TLB_ASSOC a power of two, at least 2
    parameter bit IS_ITLB   = 0
) (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               ren,
    input  logic               wen,
    input  mmu_pkg::vaddr_t    vaddr,
    input  logic               trans_on,
    input  mmu_pkg::asid_t     satp_asid,
    input  logic               fence,
    input  mmu_pkg::vaddr_t    fence_va,
    input  mmu_pkg::asid_t     fence_asid,
    output logic               tlb_miss,
    output logic               fence_done,
    output logic               hit,
    output mmu_pkg::pte_sv32_t hit_pte,
    output mmu_pkg::access_t   access,
    output logic               walk_fault,
    walk_bus_if.tlb            walk
);
    import mmu_pkg::*;

    localparam int N_SETS   = TLB_SIZE / TLB_ASSOC;
    localparam int SET_BITS = $clog2(N_SETS);
    localparam int TAG_BITS = $bits(vpn_t) - SET_BITS;
    localparam int WAY_BITS = $clog2(TLB_ASSOC) + (TLB_ASSOC == 1);

    typedef struct packed {
        logic                valid;
        asid_t               asid;
        logic [TAG_BITS-1:0] tag;
        pte_sv32_t           pte;
    } way_t;

    tlb_state_t state;
    tlb_state_t next_state;

    // sweep position, shared by reset clear and fence
    logic [SET_BITS-1:0] sweep_set;
    logic [WAY_BITS-1:0] sweep_way;
    logic                sweep_last;
    way_t                sweep_entry;
    logic                sweep_hit;

    logic   fence_req;   // fence seen outside LOOKUP
    logic   fence_any;
    vaddr_t fence_va_q;
    asid_t  fence_asid_q;

    logic [WAY_BITS-1:0] last_used [N_SETS];  // NRU pointer per set
    logic [WAY_BITS-1:0] ridx;

    vpn_t                req_vpn;
    logic [SET_BITS-1:0] req_set;
    logic [TAG_BITS-1:0] req_tag;
    logic                req;

    logic                match;
    logic [WAY_BITS-1:0] match_idx;
    pte_sv32_t           match_pte;

    way_t [TLB_ASSOC-1:0] rd_ways;
    way_t [TLB_ASSOC-1:0] wr_ways;
    way_t [TLB_ASSOC-1:0] mask_ways;
    logic                 arr_wen;
    logic [SET_BITS-1:0]  arr_sel;

    assign req_vpn   = vaddr[31:PAGE_OFFSET_BITS];
    assign req_set   = req_vpn[SET_BITS-1:0];
    assign req_tag   = req_vpn[$bits(vpn_t)-1:SET_BITS];
    assign req       = ren | wen;
    assign fence_any = fence | fence_req;

    // an ITLB only ever fetches
    assign access = IS_ITLB ? (ren ? ACCESS_INSN : ACCESS_NONE)
                  : (wen ? ACCESS_STORE : (ren ? ACCESS_LOAD : ACCESS_NONE));

    assign arr_sel = (state == CLEAR || state == FENCE) ? sweep_set : req_set;

    tlb_array #(
        .N_SETS    (N_SETS),
        .TLB_ASSOC (TLB_ASSOC)
    ) tag_pte_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (arr_sel),
        .wen   (arr_wen),
        .wval  (wr_ways),
        .wmask (mask_ways),
        .rval  (rd_ways)
    );

    always_comb begin
        match     = 1'b0;
        match_idx = '0;
        match_pte = '0;
        for (int i = 0; i < TLB_ASSOC; i++) begin
            if (rd_ways[i].valid && rd_ways[i].tag == req_tag &&
                rd_ways[i].asid == satp_asid) begin
                match     = 1'b1;
                match_idx = WAY_BITS'(i);
                match_pte = rd_ways[i].pte;
            end
        end
    end

    assign hit_pte = match_pte;

    // zero va hits every page, zero asid every space; nonzero asid spares globals
    assign sweep_entry = rd_ways[sweep_way];
    assign sweep_hit   = sweep_entry.valid
                       && (fence_va_q == '0 ||
                           {sweep_entry.tag, sweep_set} == fence_va_q[31:PAGE_OFFSET_BITS])
                       && (fence_asid_q == '0 ||
                           (sweep_entry.asid == fence_asid_q && !sweep_entry.pte.perms.global));
    assign sweep_last  = (sweep_set == SET_BITS'(N_SETS - 1)) &&
                         (sweep_way == WAY_BITS'(TLB_ASSOC - 1));

    // refill the way after the last used one
    assign ridx = (last_used[req_set] == WAY_BITS'(TLB_ASSOC - 1)) ? '0
                : last_used[req_set] + 1'b1;

    assign walk.req = (state == FETCH);
    assign walk.vpn = req_vpn;  // requester holds vaddr

    always_comb begin
        next_state = state;
        hit        = 1'b0;
        tlb_miss   = 1'b0;
        walk_fault = 1'b0;
        arr_wen    = 1'b0;
        wr_ways    = '0;
        mask_ways  = '1;
        case (state)
            CLEAR: begin
                arr_wen              = 1'b1;
                mask_ways[sweep_way] = '0;
                if (sweep_last) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (fence_any) begin
                    next_state = FENCE;
                end else if (req) begin
                    if (!trans_on || match) begin
                        hit        = 1'b1;   // bare mode answers here too
                        next_state = RESPOND;
                    end else begin
                        tlb_miss   = 1'b1;
                        next_state = FETCH;
                    end
                end
            end
            RESPOND: begin
                next_state = LOOKUP;  // request still held this cycle
            end
            FETCH: begin
                tlb_miss = 1'b1;
                if (walk.done) begin
                    walk_fault      = walk.error;
                    arr_wen         = !walk.error;
                    wr_ways[ridx]   = '{valid: 1'b1, asid: satp_asid, tag: req_tag,
                                        pte: walk.pte};
                    mask_ways[ridx] = '0;
                    next_state      = walk.error ? RESPOND : LOOKUP;
                end
            end
            FENCE: begin
                arr_wen              = sweep_hit;
                mask_ways[sweep_way] = '0;
                if (sweep_last) begin
                    next_state = LOOKUP;
                end
            end
            default: begin
                next_state = CLEAR;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= CLEAR;
            sweep_set  <= '0;
            sweep_way  <= '0;
            fence_req  <= 1'b0;
            fence_done <= 1'b0;
            for (int i = 0; i < N_SETS; i++) begin
                last_used[i] <= '0;
            end
        end else begin
            state      <= next_state;
            fence_done <= (state == FENCE) && sweep_last;
            if (state == CLEAR || state == FENCE) begin
                if (sweep_last) begin
                    sweep_set <= '0;
                    sweep_way <= '0;
                end else if (sweep_way == WAY_BITS'(TLB_ASSOC - 1)) begin
                    sweep_set <= sweep_set + 1'b1;
                    sweep_way <= '0;
                end else begin
                    sweep_way <= sweep_way + 1'b1;
                end
            end
            if (state == LOOKUP) begin
                fence_req <= 1'b0;  // taken up by this LOOKUP
            end else if (fence) begin
                fence_req <= 1'b1;
            end
            if (hit && trans_on) begin
                last_used[req_set] <= match_idx;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fence) begin
            fence_va_q   <= fence_va;
            fence_asid_q <= fence_asid;
        end
    end

endmodule

/* source/tlb_array.sv */
`timescale 1ns/1ps

module tlb_array #(
    parameter int  N_SETS    = 8,  // at least 2
    parameter int  TLB_ASSOC = 2,
    localparam int SET_BITS  = $clog2(N_SETS),
    localparam int WAY_W     = 1 + mmu_pkg::ASID_LENGTH + $bits(mmu_pkg::vpn_t) - SET_BITS
                               + $bits(mmu_pkg::pte_sv32_t),
    localparam int ROW_W     = WAY_W * TLB_ASSOC
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic [SET_BITS-1:0] sel,
    input  logic                wen,
    input  logic [ROW_W-1:0]    wval,
    input  logic [ROW_W-1:0]    wmask,  // 1 keeps the stored bit
    output logic [ROW_W-1:0]    rval
);

    // one row per set, all ways side by side
    logic [ROW_W-1:0] rows [N_SETS];

    assign rval = rows[sel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                rows[i] <= '0;
            end
        end else if (wen) begin
            rows[sel] <= (rows[sel] & wmask) | (wval & ~wmask);
        end
    end

endmodule

/* source/walk_bus_if.sv */
`timescale 1ns/1ps

interface walk_bus_if;
    import mmu_pkg::*;

    logic      req;    // level, held until done
    vpn_t      vpn;
    pte_sv32_t pte;    // valid with done unless error
    logic      done;   // one cycle
    logic      error;

    modport tlb (
        output req, vpn,
        input  pte, done, error
    );

    modport walker (
        input  req, vpn,
        output pte, done, error
    );

endinterface

/* sources.f */
source/mmu_pkg.sv
source/walk_bus_if.sv
source/tlb_array.sv
source/tlb.sv
source/page_walker.sv
source/page_perm_check.sv
source/mmu_top.sv
verification/mmu_tb.sv

/* verification/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int          TLB_SIZE   = 16;
    localparam int          N_REQUESTS = 60;            // upper bound on requests below
    localparam logic [31:0] SEED       = 32'h099e_ab30;
    localparam ppn_t        ROOT_PPN   = 22'h000100;
    localparam ppn_t        L0_BASE    = 22'h000200;    // level-0 table per 4 MiB region

    // PTE permission bits
    localparam logic [9:0] PTE_V = 10'h001;
    localparam logic [9:0] PTE_R = 10'h002;
    localparam logic [9:0] PTE_W = 10'h004;
    localparam logic [9:0] PTE_X = 10'h008;
    localparam logic [9:0] PTE_U = 10'h010;
    localparam logic [9:0] PTE_G = 10'h020;
    localparam logic [9:0] PTE_A = 10'h040;
    localparam logic [9:0] PTE_D = 10'h080;
    localparam logic [9:0] RWAD  = PTE_V | PTE_R | PTE_W | PTE_A | PTE_D;

    logic        CLK        = 1'b0;
    logic        nRST       = 1'b0;
    logic        ren        = 1'b0;
    logic        wen        = 1'b0;
    vaddr_t      vaddr      = '0;
    logic        trans_on   = 1'b0;
    logic        priv_user  = 1'b0;
    logic        sum        = 1'b0;
    asid_t       satp_asid  = '0;
    ppn_t        satp_ppn   = ROOT_PPN;
    logic        fence      = 1'b0;
    vaddr_t      fence_va   = '0;
    asid_t       fence_asid = '0;
    logic [31:0] mem_rdata  = '0;
    logic        mem_busy   = 1'b1;
    logic        mem_error  = 1'b0;

    logic   busy;
    paddr_t paddr;
    logic   fault_load_page;
    logic   fault_store_page;
    logic   fault_insn_page;
    logic   tlb_miss;
    logic   fence_done;
    logic   mem_ren;
    paddr_t mem_addr;

    logic [31:0] pt_mem [paddr_t];    // page-table memory
    bit          bad_addr [paddr_t];  // reads here return mem_error
    int          n_reads    = 0;
    int          delay_left = 0;
    logic [31:0] delay_rng  = SEED;
    logic [31:0] stim_rng   = SEED;

    mmu_top #(
        .TLB_SIZE  (TLB_SIZE),
        .TLB_ASSOC (2),
        .IS_ITLB   (0)
    ) dut0 (.*);

    initial begin
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory model, 0 to 3 busy cycles per read
    always @(posedge CLK) begin
        if (!mem_busy) begin
            mem_busy  <= 1'b1;
            mem_error <= 1'b0;
            n_reads   <= n_reads + 1;
            delay_rng = xorshift32(delay_rng);
            delay_left <= int'(delay_rng[1:0]);
        end else if (mem_ren) begin
            if (delay_left == 0) begin
                mem_busy  <= 1'b0;
                mem_rdata <= pt_mem.exists(mem_addr) ? pt_mem[mem_addr] : 32'h0;
                mem_error <= bad_addr.exists(mem_addr);
            end else begin
                delay_left <= delay_left - 1;
            end
        end
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    initial begin : watchdog
        repeat (400 * N_REQUESTS + 2000) @(posedge CLK);
        stop_with_error("the run timed out before all tests finished");
    end

    function automatic paddr_t pte_addr(input ppn_t base, input logic [9:0] index);
        return {base, index, 2'b00};
    endfunction

    function automatic pte_sv32_t read_pte(input paddr_t addr);
        return pt_mem.exists(addr) ? pte_sv32_t'(pt_mem[addr]) : pte_sv32_t'(0);
    endfunction

    // pointer at level 1, leaf at level 0
    task automatic map_page(input vaddr_t va, input ppn_t leaf_ppn, input logic [9:0] perms);
        ppn_t l0;
        l0 = L0_BASE + ppn_t'(va[31:22]);
        pt_mem[pte_addr(ROOT_PPN, va[31:22])] = {l0, PTE_V};
        pt_mem[pte_addr(l0, va[21:12])]       = {leaf_ppn, perms};
    endtask

    // expected response, returns {insn, store, load} fault flags
    function automatic logic [2:0] expected_result(input vaddr_t va, input logic st,
                                                   output paddr_t pa);
        paddr_t    addr;
        pte_sv32_t pte;
        logic      deny;
        pa   = paddr_t'(va);
        deny = 1'b0;
        if (trans_on) begin
            addr = pte_addr(satp_ppn, va[31:22]);
            pte  = read_pte(addr);
            // level 1 must be a plain pointer
            if (bad_addr.exists(addr) || !pte.perms.valid || pte.perms.readable ||
                pte.perms.writable || pte.perms.executable) begin
                deny = 1'b1;
            end else begin
                addr = pte_addr(pte.ppn, va[21:12]);
                pte  = read_pte(addr);
                deny = bad_addr.exists(addr) || !pte.perms.valid
                     || !(pte.perms.readable || pte.perms.executable)
                     || (pte.perms.writable && !pte.perms.readable)
                     || !pte.perms.accessed
                     || (st && !(pte.perms.writable && pte.perms.dirty))
                     || (!st && !pte.perms.readable)
                     || (priv_user && !pte.perms.user)
                     || (!priv_user && pte.perms.user && !sum);
            end
            pa = deny ? paddr_t'(0) : {pte.ppn, va[11:0]};
        end
        return deny ? (st ? 3'b010 : 3'b001) : 3'b000;
    endfunction

    task automatic compare_paddr(input paddr_t got, input paddr_t exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s paddr %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic compare_fault(input logic [2:0] got, input logic [2:0] exp,
                                 input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s fault flags %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic compare_walks(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s took %0d reads, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED at %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    task automatic set_mode(input logic trans, input logic user, input logic sum_bit,
                            input asid_t asid);
        @(posedge CLK);
        trans_on  <= trans;
        priv_user <= user;
        sum       <= sum_bit;
        satp_asid <= asid;
    endtask

    // one request, checked against the reference; walks < 0 skips the read count
    task automatic request_access(input vaddr_t va, input logic st, input int walks,
                                  input string what);
        paddr_t     exp_pa;
        logic [2:0] exp_flt;
        int         reads_before;
        logic       miss_seen;
        @(negedge CLK);
        reads_before = n_reads;
        exp_flt      = expected_result(va, st, exp_pa);
        miss_seen    = 1'b0;
        @(posedge CLK);
        ren   <= !st;
        wen   <= st;
        vaddr <= va;
        do begin
            @(negedge CLK);
            miss_seen = miss_seen | tlb_miss;
        end while (busy);
        compare_paddr(paddr, exp_pa, what);
        compare_fault({fault_insn_page, fault_store_page, fault_load_page}, exp_flt, what);
        if (walks >= 0) begin
            compare_walks(n_reads - reads_before, walks, what);
            compare_bit(miss_seen, walks > 0, {what, " tlb_miss"});
        end
        @(posedge CLK);
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic run_fence(input vaddr_t va, input asid_t asid);
        int waited;
        @(posedge CLK);
        fence      <= 1'b1;
        fence_va   <= va;
        fence_asid <= asid;
        @(posedge CLK);
        fence <= 1'b0;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
        end while (!fence_done && waited < 100);
        if (!fence_done) begin
            stop_with_error("fence_done did not pulse within 100 cycles of the fence");
        end
    endtask

    initial begin : stimulus
        vaddr_t     va;
        paddr_t     exp_pa;
        logic [2:0] exp_flt;
        // everything idle while reset is held
        repeat (8) begin
            @(negedge CLK);
            compare_bit(busy, 1'b1, "busy in reset");
            compare_bit(mem_ren, 1'b0, "mem_ren in reset");
            compare_bit(tlb_miss, 1'b0, "tlb_miss in reset");
            compare_bit(fence_done, 1'b0, "fence_done in reset");
            compare_fault({fault_insn_page, fault_store_page, fault_load_page}, 3'b000,
                          "reset");
        end

        // request held from reset release, answered only after the clear
        exp_flt = expected_result(32'h8765_4321, 1'b0, exp_pa);
        @(posedge CLK);
        nRST  <= 1'b1;
        ren   <= 1'b1;
        vaddr <= 32'h8765_4321;
        repeat (TLB_SIZE) begin
            @(negedge CLK);
            compare_bit(busy, 1'b1, "busy during clear");
        end
        do begin
            @(negedge CLK);
        end while (busy);
        compare_paddr(paddr, exp_pa, "request held over clear");
        compare_fault({fault_insn_page, fault_store_page, fault_load_page}, exp_flt,
                      "request held over clear");
        @(posedge CLK);
        ren <= 1'b0;

        // bare mode, random addresses pass through
        repeat (16) begin
            stim_rng = xorshift32(stim_rng);
            va       = stim_rng;
            request_access(va, stim_rng[7], 0, "bare mode");
        end

        // miss then hit, then NRU in set 3 (A, B, C share the set)
        map_page(32'h0040_3000, 22'h2A_BCDE, RWAD);
        map_page(32'h0041_3000, 22'h01_1111, RWAD);
        map_page(32'h0042_3000, 22'h01_2222, RWAD);
        set_mode(1'b1, 1'b0, 1'b0, 9'd1);
        request_access(32'h0040_3abc, 1'b0, 2, "first load A");
        request_access(32'h0040_3123, 1'b0, 0, "repeat load A");
        request_access(32'h0040_3ffc, 1'b1, 0, "store A");
        request_access(32'h0041_3000, 1'b0, 2, "load B");
        request_access(32'h0040_3000, 1'b0, 0, "refresh A");
        request_access(32'h0042_3010, 1'b0, 2, "load C evicts B");
        request_access(32'h0040_3020, 1'b0, 0, "A survives");
        request_access(32'h0041_3030, 1'b0, 2, "B walks again");
        request_access(32'h0040_3040, 1'b0, 0, "A still cached");

        // permission faults
        map_page(32'h0080_4000, 22'h00_0400, PTE_V | PTE_X | PTE_A);
        map_page(32'h0080_5000, 22'h00_0500, PTE_V | PTE_R | PTE_A | PTE_D);
        map_page(32'h0080_6000, 22'h00_0600, PTE_V | PTE_R | PTE_W | PTE_D);
        map_page(32'h0080_7000, 22'h00_0700, PTE_V | PTE_R | PTE_W | PTE_A);
        map_page(32'h0080_8000, 22'h00_0800, RWAD | PTE_U);
        map_page(32'h0080_9000, 22'h00_0900, RWAD);
        request_access(32'h0080_4004, 1'b0, 2, "load without R");
        request_access(32'h0080_5008, 1'b0, 2, "load read-only page");
        request_access(32'h0080_500c, 1'b1, 0, "store without W");
        request_access(32'h0080_6000, 1'b0, 2, "load without A");
        request_access(32'h0080_7010, 1'b1, 2, "store without D");
        request_access(32'h0080_7014, 1'b0, 0, "load without D");
        request_access(32'h0080_8020, 1'b0, 2, "supervisor on user page");
        set_mode(1'b1, 1'b0, 1'b1, 9'd1);
        request_access(32'h0080_8024, 1'b0, 0, "supervisor load with sum");
        request_access(32'h0080_8028, 1'b1, 0, "supervisor store with sum");
        set_mode(1'b1, 1'b1, 1'b0, 9'd1);
        request_access(32'h0080_802c, 1'b0, 0, "user on user page");
        request_access(32'h0080_9030, 1'b0, 2, "user on supervisor page");
        set_mode(1'b1, 1'b0, 1'b0, 9'd1);
        request_access(32'h0080_9034, 1'b1, 0, "supervisor store");

        // walk faults are never cached
        map_page(32'h00c0_2000, 22'h00_0c02, RWAD);
        bad_addr[pte_addr(L0_BASE + 22'd3, 10'd2)] = 1'b1;
        request_access(32'h00c0_1000, 1'b0, 2, "invalid leaf");
        request_access(32'h00c0_1004, 1'b0, 2, "invalid leaf again");
        request_access(32'h00c0_1008, 1'b1, 2, "store to invalid leaf");
        request_access(32'h00c0_2000, 1'b0, 2, "mem_error on leaf");
        bad_addr.delete(pte_addr(L0_BASE + 22'd3, 10'd2));
        request_access(32'h00c0_2004, 1'b0, 2, "leaf after mem_error");
        pt_mem[pte_addr(ROOT_PPN, 10'd4)] = {22'h00_1000, RWAD};  // megapage leaf
        request_access(32'h0100_0000, 1'b0, 1, "level-1 leaf");
        request_access(32'h0140_0000, 1'b0, 1, "invalid level-1 entry");

        // fences: all, by ASID, by address
        map_page(32'h0180_0000, 22'h00_1800, RWAD | PTE_G);
        map_page(32'h0180_1000, 22'h00_1801, RWAD);
        run_fence(32'h0, 9'd0);
        request_access(32'h0040_3000, 1'b0, 2, "A after full fence");
        request_access(32'h0040_3004, 1'b0, 0, "A cached again");
        request_access(32'h0180_0000, 1'b0, 2, "global page");
        request_access(32'h0180_1000, 1'b0, 2, "page in ASID 1");
        set_mode(1'b1, 1'b0, 1'b0, 9'd2);
        request_access(32'h0180_1004, 1'b0, 2, "page in ASID 2");
        run_fence(32'h0, 9'd1);
        request_access(32'h0180_1008, 1'b0, 0, "ASID 2 spared");
        set_mode(1'b1, 1'b0, 1'b0, 9'd1);
        request_access(32'h0180_0008, 1'b0, 0, "global spared");
        request_access(32'h0180_100c, 1'b0, 2, "ASID 1 page fenced");
        request_access(32'h0040_3008, 1'b0, 2, "A fenced by ASID");
        run_fence(32'h0180_1000, 9'd0);
        request_access(32'h0180_0010, 1'b0, 0, "other page after address fence");
        request_access(32'h0040_3010, 1'b0, 0, "A after address fence");
        request_access(32'h0180_1010, 1'b0, 2, "fenced page in ASID 1");
        set_mode(1'b1, 1'b0, 1'b0, 9'd2);
        request_access(32'h0180_1014, 1'b0, 2, "fenced page in ASID 2");

        $display("No errors");
        $finish;
    end

endmodule
